// ==== rtl/dbg_pkg.sv ====
/*
 * Shared widths, field lengths, ASCII constants and the field enum for the
 * register-dump formatter. Modules pull it in with a wildcard import.
 */
package dbg_pkg;

    localparam int PC_W       = 20;
    localparam int PC_NIBBLES = 5;
    localparam int ST_W       = 16;
    localparam int HST_W      = 4;
    localparam int P_W        = 4;
    localparam int RSTK_PTR_W = 3;
    localparam int CHAR_W     = 8;
    localparam int BUF_AW     = 6;           // 64 entry text buffer
    localparam int IDX_W      = 5;           // enough for the 16 ST bits
    localparam int LABEL_MAX  = 6;           // longest label, " HST: "

    localparam logic [CHAR_W-1:0] CHAR_LF = 8'd10;
    localparam logic [CHAR_W-1:0] CHAR_CR = 8'd13;
    localparam logic [CHAR_W-1:0] CHAR_0  = "0";
    localparam logic [CHAR_W-1:0] CHAR_A  = "A";

    // label text, right justified in the vector
    localparam logic [LABEL_MAX*CHAR_W-1:0] LBL_PC   = "PC: ";
    localparam logic [LABEL_MAX*CHAR_W-1:0] LBL_MODE = " h: ";
    localparam logic [LABEL_MAX*CHAR_W-1:0] LBL_RP   = " rp: ";
    localparam logic [LABEL_MAX*CHAR_W-1:0] LBL_P    = "P: ";
    localparam logic [LABEL_MAX*CHAR_W-1:0] LBL_HST  = " HST: ";
    localparam logic [LABEL_MAX*CHAR_W-1:0] LBL_ST   = " ST: ";
    localparam logic [3*CHAR_W-1:0]         TXT_HEX  = "HEX";
    localparam logic [3*CHAR_W-1:0]         TXT_DEC  = "DEC";

    // output order of the dump, then the two control states
    typedef enum logic [3:0] {
        F_PC_LABEL, F_PC_VALUE, F_MODE_LABEL, F_MODE_VALUE, F_RP_LABEL, F_RP_VALUE, F_NL_0,
        F_P_LABEL, F_P_VALUE, F_HST_LABEL, F_HST_VALUE, F_ST_LABEL, F_ST_VALUE, F_NL_1,
        F_IDLE, F_DRAIN
    } field_e;

    localparam int FIELD_LEN_PC_LABEL   = 4;
    localparam int FIELD_LEN_PC_VALUE   = 5;
    localparam int FIELD_LEN_MODE_LABEL = 4;
    localparam int FIELD_LEN_MODE_VALUE = 3;
    localparam int FIELD_LEN_RP_LABEL   = 5;
    localparam int FIELD_LEN_RP_VALUE   = 1;
    localparam int FIELD_LEN_NL_0       = 2;
    localparam int FIELD_LEN_P_LABEL    = 3;
    localparam int FIELD_LEN_P_VALUE    = 1;
    localparam int FIELD_LEN_HST_LABEL  = 6;
    localparam int FIELD_LEN_HST_VALUE  = 4;
    localparam int FIELD_LEN_ST_LABEL   = 5;
    localparam int FIELD_LEN_ST_VALUE   = 16;
    localparam int FIELD_LEN_NL_1       = 2;

    localparam int DUMP_LEN = FIELD_LEN_PC_LABEL + FIELD_LEN_PC_VALUE + FIELD_LEN_MODE_LABEL
                            + FIELD_LEN_MODE_VALUE + FIELD_LEN_RP_LABEL + FIELD_LEN_RP_VALUE
                            + FIELD_LEN_NL_0 + FIELD_LEN_P_LABEL + FIELD_LEN_P_VALUE
                            + FIELD_LEN_HST_LABEL + FIELD_LEN_HST_VALUE + FIELD_LEN_ST_LABEL
                            + FIELD_LEN_ST_VALUE + FIELD_LEN_NL_1;   // 61

endpackage

// ==== rtl/dbg_buf_if.sv ====
/*
 * Link between the dump sequencer and the text buffer. The sequencer
 * writes characters and starts the drain, the buffer reports the end of it.
 */
`timescale 1ns/10ps

interface dbg_buf_if;

    logic                       wr_en;          // store wr_char this cycle
    logic [dbg_pkg::CHAR_W-1:0] wr_char;
    logic                       drain_start;    // pulse after the last write
    logic                       drained;        // pulse with the last valid

    modport seq (
        output wr_en,
        output wr_char,
        output drain_start,
        input  drained
    );

    modport buffer (
        input  wr_en,
        input  wr_char,
        input  drain_start,
        output drained
    );

endinterface

// ==== rtl/dbg_sequencer.sv ====
/*
 * Control FSM of the dump. Accepts a start while idle, walks every field
 * one character per clock and hands each character to the text buffer,
 * then starts the drain and waits for the buffer to finish.
 */
`timescale 1ns/10ps

module dbg_sequencer import dbg_pkg::*; (
    input  logic              i_clk,
    input  logic              i_reset,
    input  logic              i_dump_start,
    input  logic [CHAR_W-1:0] i_char,
    output field_e            o_field,
    output logic [IDX_W-1:0]  o_index,
    output logic              o_capture,
    output logic              o_busy,
    dbg_buf_if.seq            bif
);

    field_e           field_q;
    logic [IDX_W-1:0] index_q;
    logic             writing_q;
    logic             drain_start_q;
    logic             field_done;

    function automatic logic [IDX_W-1:0] field_last(input field_e f);
        int len;
        case (f)
            F_PC_LABEL:   len = FIELD_LEN_PC_LABEL;
            F_PC_VALUE:   len = FIELD_LEN_PC_VALUE;
            F_MODE_LABEL: len = FIELD_LEN_MODE_LABEL;
            F_MODE_VALUE: len = FIELD_LEN_MODE_VALUE;
            F_RP_LABEL:   len = FIELD_LEN_RP_LABEL;
            F_RP_VALUE:   len = FIELD_LEN_RP_VALUE;
            F_NL_0:       len = FIELD_LEN_NL_0;
            F_P_LABEL:    len = FIELD_LEN_P_LABEL;
            F_P_VALUE:    len = FIELD_LEN_P_VALUE;
            F_HST_LABEL:  len = FIELD_LEN_HST_LABEL;
            F_HST_VALUE:  len = FIELD_LEN_HST_VALUE;
            F_ST_LABEL:   len = FIELD_LEN_ST_LABEL;
            F_ST_VALUE:   len = FIELD_LEN_ST_VALUE;
            F_NL_1:       len = FIELD_LEN_NL_1;
            default:      len = 1;              // idle and drain hold index at 0
        endcase
        return IDX_W'(len - 1);
    endfunction

    assign field_done = (index_q == field_last(field_q));
    assign o_capture  = (field_q == F_IDLE) && i_dump_start;   // starts while busy are dropped
    assign o_busy     = (field_q != F_IDLE);
    assign o_field    = field_q;
    assign o_index    = index_q;

    assign bif.wr_en       = writing_q;
    assign bif.wr_char     = i_char;
    assign bif.drain_start = drain_start_q;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            field_q       <= F_IDLE;
            index_q       <= '0;
            writing_q     <= 1'b0;
            drain_start_q <= 1'b0;
        end else begin
            drain_start_q <= 1'b0;
            case (field_q)
                F_IDLE: begin
                    if (o_capture) begin
                        field_q   <= F_PC_LABEL;
                        index_q   <= '0;
                        writing_q <= 1'b1;
                    end
                end
                F_DRAIN: begin
                    if (bif.drained) begin
                        field_q <= F_IDLE;         // busy drops next cycle
                    end
                end
                default: begin
                    if (!field_done) begin
                        index_q <= index_q + 1'b1;
                    end else if (field_q == F_NL_1) begin
                        // last character of the text goes out this cycle
                        index_q       <= '0;
                        field_q       <= F_DRAIN;
                        writing_q     <= 1'b0;
                        drain_start_q <= 1'b1;
                    end else begin
                        index_q <= '0;
                        field_q <= field_e'(field_q + 4'd1);
                    end
                end
            endcase
        end
    end

    // the write flag and the field walk must agree
    assert property (@(posedge i_clk) disable iff (i_reset)
        bif.wr_en |-> !(field_q inside {F_IDLE, F_DRAIN}))
        else $error("write strobe outside the text fields");

endmodule

// ==== rtl/dbg_snapshot.sv ====
/*
 * Holds the CPU state captured at the start of a dump and returns the
 * digit value for the field and position the sequencer is on.
 */
`timescale 1ns/10ps

module dbg_snapshot import dbg_pkg::*; (
    input  logic                  i_clk,
    input  logic                  i_reset,
    input  logic                  i_capture,
    input  logic [PC_W-1:0]       i_pc,
    input  logic                  i_alu_mode,
    input  logic [RSTK_PTR_W-1:0] i_rstk_ptr,
    input  logic [P_W-1:0]        i_p,
    input  logic [HST_W-1:0]      i_hst,
    input  logic [ST_W-1:0]       i_st,
    input  field_e                i_field,
    input  logic [IDX_W-1:0]      i_index,
    output logic [3:0]            o_digit
);

    logic [PC_W-1:0]       pc_q;
    logic                  mode_q;       // set means decimal
    logic [RSTK_PTR_W-1:0] rstk_q;
    logic [P_W-1:0]        p_q;
    logic [HST_W-1:0]      hst_q;
    logic [ST_W-1:0]       st_q;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            pc_q   <= '0;
            mode_q <= 1'b0;
            rstk_q <= '0;
            p_q    <= '0;
            hst_q  <= '0;
            st_q   <= '0;
        end else if (i_capture) begin
            pc_q   <= i_pc;
            mode_q <= i_alu_mode;
            rstk_q <= i_rstk_ptr;
            p_q    <= i_p;
            hst_q  <= i_hst;
            st_q   <= i_st;
        end
    end

    // most significant nibble or bit comes first
    always_comb begin
        case (i_field)
            F_PC_VALUE:   o_digit = pc_q[4*(PC_NIBBLES-1-int'(i_index)) +: 4];
            F_MODE_VALUE: o_digit = {3'b000, mode_q};
            F_RP_VALUE:   o_digit = 4'(rstk_q);
            F_P_VALUE:    o_digit = p_q;
            F_HST_VALUE:  o_digit = {3'b000, hst_q[HST_W-1-int'(i_index)]};
            F_ST_VALUE:   o_digit = {3'b000, st_q[ST_W-1-int'(i_index)]};
            default:      o_digit = 4'd0;    // labels ignore it
        endcase
    end

endmodule

// ==== rtl/dbg_char_gen.sv ====
/*
 * Character generator for the dump. Combinational: picks label bytes from
 * the fixed strings and turns snapshot digits into hex, binary or mode text.
 */
`timescale 1ns/10ps

module dbg_char_gen import dbg_pkg::*; (
    input  field_e            i_field,
    input  logic [IDX_W-1:0]  i_index,
    input  logic [3:0]        i_digit,
    output logic [CHAR_W-1:0] o_char
);

    logic [LABEL_MAX*CHAR_W-1:0] mode_txt;    // right justified like the labels

    // byte idx of a right justified string of len characters
    function automatic logic [CHAR_W-1:0] pick(input logic [LABEL_MAX*CHAR_W-1:0] s,
                                               input int len,
                                               input logic [IDX_W-1:0] idx);
        return s[CHAR_W*(len-1-int'(idx)) +: CHAR_W];
    endfunction

    function automatic logic [CHAR_W-1:0] hex_char(input logic [3:0] d);
        if (d < 4'd10) begin
            return CHAR_0 + CHAR_W'(d);
        end
        return CHAR_A + CHAR_W'(d - 4'd10);
    endfunction

    assign mode_txt = i_digit[0] ? TXT_DEC : TXT_HEX;

    always_comb begin
        case (i_field)
            F_PC_LABEL:   o_char = pick(LBL_PC, FIELD_LEN_PC_LABEL, i_index);
            F_MODE_LABEL: o_char = pick(LBL_MODE, FIELD_LEN_MODE_LABEL, i_index);
            F_RP_LABEL:   o_char = pick(LBL_RP, FIELD_LEN_RP_LABEL, i_index);
            F_P_LABEL:    o_char = pick(LBL_P, FIELD_LEN_P_LABEL, i_index);
            F_HST_LABEL:  o_char = pick(LBL_HST, FIELD_LEN_HST_LABEL, i_index);
            F_ST_LABEL:   o_char = pick(LBL_ST, FIELD_LEN_ST_LABEL, i_index);
            F_MODE_VALUE: o_char = pick(mode_txt, FIELD_LEN_MODE_VALUE, i_index);
            F_PC_VALUE,
            F_RP_VALUE,
            F_P_VALUE:    o_char = hex_char(i_digit);
            F_HST_VALUE,
            F_ST_VALUE:   o_char = CHAR_0 + CHAR_W'(i_digit[0]);   // single bit
            F_NL_0:       o_char = pick({CHAR_LF, CHAR_CR}, FIELD_LEN_NL_0, i_index);
            F_NL_1:       o_char = pick({CHAR_LF, CHAR_CR}, FIELD_LEN_NL_1, i_index);
            default:      o_char = '0;   // nothing is written here
        endcase
    end

endmodule

// ==== rtl/dbg_text_buffer.sv ====
/*
 * Text buffer of the dump. Stores one character per write, and after
 * drain_start sends them in order to the serial port, one valid pulse at a
 * time while the port is not busy. Pointers rewind after the last one.
 */
`timescale 1ns/10ps

module dbg_text_buffer import dbg_pkg::*; (
    input  logic              i_clk,
    input  logic              i_reset,
    input  logic              i_serial_busy,
    output logic [CHAR_W-1:0] o_char,
    output logic              o_char_valid,
    dbg_buf_if.buffer         bif
);

    logic [CHAR_W-1:0] mem [0:(1<<BUF_AW)-1];
    logic [BUF_AW-1:0] wr_ptr;
    logic [BUF_AW-1:0] rd_ptr;
    logic              draining;
    logic              drained_q;
    logic              send;
    logic              last;

    // one gap cycle after every valid
    assign send = draining && !o_char_valid && !i_serial_busy;
    assign last = (rd_ptr == BUF_AW'(DUMP_LEN - 1));
    assign bif.drained = drained_q;

    always_ff @(posedge i_clk) begin
        if (bif.wr_en) begin
            mem[wr_ptr] <= bif.wr_char;
        end
        if (send) begin
            o_char <= mem[rd_ptr];
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            wr_ptr       <= '0;
            rd_ptr       <= '0;
            draining     <= 1'b0;
            drained_q    <= 1'b0;
            o_char_valid <= 1'b0;
        end else begin
            o_char_valid <= send;
            drained_q    <= send && last;   // lines up with the last valid
            if (bif.wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (bif.drain_start) begin
                draining <= 1'b1;
            end
            if (send) begin
                if (last) begin
                    draining <= 1'b0;
                    rd_ptr   <= '0;
                    wr_ptr   <= '0;    // ready for the next dump
                end else begin
                    rd_ptr <= rd_ptr + 1'b1;
                end
            end
        end
    end

    assert property (@(posedge i_clk) disable iff (i_reset)
        o_char_valid |=> !o_char_valid)
        else $error("char valid held for two cycles");

    // sequencer must not write once the drain has begun
    assert property (@(posedge i_clk) disable iff (i_reset)
        bif.wr_en |-> !draining)
        else $error("write into the buffer while draining");

endmodule

// ==== rtl/dbg_dump_top.sv ====
/*
 * Top level of the register-dump formatter. A pulse on i_dump_start while
 * o_busy is low captures the CPU state; the two-line text then goes out on
 * o_char with one o_char_valid pulse per character, paced by i_serial_busy.
 */
`timescale 1ns/10ps

module dbg_dump_top import dbg_pkg::*; (
    input  logic                  i_clk,
    input  logic                  i_reset,
    input  logic                  i_dump_start,
    input  logic [PC_W-1:0]       i_pc,
    input  logic                  i_alu_mode,
    input  logic [RSTK_PTR_W-1:0] i_rstk_ptr,
    input  logic [P_W-1:0]        i_p,
    input  logic [HST_W-1:0]      i_hst,
    input  logic [ST_W-1:0]       i_st,
    input  logic                  i_serial_busy,
    output logic [CHAR_W-1:0]     o_char,
    output logic                  o_char_valid,
    output logic                  o_busy
);

    field_e            field;
    logic [IDX_W-1:0]  index;
    logic              capture;
    logic [3:0]        digit;
    logic [CHAR_W-1:0] char_out;

    dbg_buf_if u_bif ();

    dbg_sequencer u_seq (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .i_dump_start (i_dump_start),
        .i_char       (char_out),
        .o_field      (field),
        .o_index      (index),
        .o_capture    (capture),
        .o_busy       (o_busy),
        .bif          (u_bif.seq)
    );

    dbg_snapshot u_snap (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_capture  (capture),
        .i_pc       (i_pc),
        .i_alu_mode (i_alu_mode),
        .i_rstk_ptr (i_rstk_ptr),
        .i_p        (i_p),
        .i_hst      (i_hst),
        .i_st       (i_st),
        .i_field    (field),
        .i_index    (index),
        .o_digit    (digit)
    );

    dbg_char_gen u_chargen (
        .i_field (field),
        .i_index (index),
        .i_digit (digit),
        .o_char  (char_out)
    );

    dbg_text_buffer u_txbuf (
        .i_clk         (i_clk),
        .i_reset       (i_reset),
        .i_serial_busy (i_serial_busy),
        .o_char        (o_char),
        .o_char_valid  (o_char_valid),
        .bif           (u_bif.buffer)
    );

endmodule

// ==== bench/tb_clock_gen.sv ====
/*
 * Testbench clock and reset source. Free-running 20 ns clock, reset held
 * high for the first 8 rising edges and released on an edge.
 */
`timescale 1ns/10ps

module tb_clock_gen (
    output logic o_clk,
    output logic o_reset
);

    localparam int HALF_PERIOD  = 10;    // 20 ns period
    localparam int RESET_CYCLES = 8;

    initial begin
        o_clk   = 1'b0;
        o_reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge o_clk);
        o_reset <= 1'b0;
    end

    always #(HALF_PERIOD) o_clk = ~o_clk;

endmodule

// ==== bench/tb_dbg_dump.sv ====
/*
 * Testbench of the register-dump formatter. Runs fixed, random, back-pressured
 * and disturbed dumps and checks every character against a string built here
 * from the dump format. The first mismatch or timeout ends the run.
 */
`timescale 1ns/10ps

module tb_dbg_dump import dbg_pkg::*; ();

    localparam int RANDOM_SEED = 59;
    localparam int WAIT_LIMIT  = 3000;    // cycles per wait loop

    logic                  clk;
    logic                  reset;
    logic                  dump_start;
    logic [PC_W-1:0]       pc;
    logic                  alu_mode;
    logic [RSTK_PTR_W-1:0] rstk_ptr;
    logic [P_W-1:0]        p;
    logic [HST_W-1:0]      hst;
    logic [ST_W-1:0]       st;
    logic                  serial_busy;
    logic [CHAR_W-1:0]     o_char;
    logic                  o_char_valid;
    logic                  o_busy;

    string test_name = "none";
    string expected_text = "";
    int    char_count = 0;
    bit    bp_on = 1'b0;          // random serial back-pressure
    logic  prev_valid = 1'b0;
    logic  prev_busy = 1'b0;

    tb_clock_gen u_clk (
        .o_clk   (clk),
        .o_reset (reset)
    );

    dbg_dump_top dut (
        .i_clk         (clk),
        .i_reset       (reset),
        .i_dump_start  (dump_start),
        .i_pc          (pc),
        .i_alu_mode    (alu_mode),
        .i_rstk_ptr    (rstk_ptr),
        .i_p           (p),
        .i_hst         (hst),
        .i_st          (st),
        .i_serial_busy (serial_busy),
        .o_char        (o_char),
        .o_char_valid  (o_char_valid),
        .o_busy        (o_busy)
    );

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("Simulation failed");
        $fatal(1, "run stopped at first failure");
    endtask

    function automatic string hex_digit(input logic [3:0] d);
        string digits;
        digits = "0123456789ABCDEF";
        return digits.substr(int'(d), int'(d));
    endfunction

    function automatic string bits_text(input logic [15:0] v, input int width);
        string s;
        string one_bit;
        s = "";
        for (int i = width - 1; i >= 0; i--) begin
            one_bit = v[i] ? "1" : "0";
            s = {s, one_bit};
        end
        return s;
    endfunction

    // both lines of the dump text, msb first in every field
    function automatic string expected_dump(input logic [PC_W-1:0] pc_v, input logic mode_v,
                                            input logic [RSTK_PTR_W-1:0] rp_v,
                                            input logic [P_W-1:0] p_v,
                                            input logic [HST_W-1:0] hst_v,
                                            input logic [ST_W-1:0] st_v);
        string s;
        string mode_txt;
        mode_txt = mode_v ? "DEC" : "HEX";
        s = "PC: ";
        for (int n = PC_NIBBLES - 1; n >= 0; n--) begin
            s = {s, hex_digit(pc_v[4*n +: 4])};
        end
        s = {s, " h: ", mode_txt, " rp: ", hex_digit(4'(rp_v)), "\n\r"};
        s = {s, "P: ", hex_digit(p_v), " HST: ", bits_text(16'(hst_v), HST_W)};
        s = {s, " ST: ", bits_text(st_v, ST_W), "\n\r"};
        return s;
    endfunction

    // compare every character as it leaves the DUT
    always @(negedge clk) begin
        if (!reset) begin
            assert (!(o_char_valid && prev_valid))
                else abort_run($sformatf("%s: char valid high on two cycles in a row", test_name));
            assert (!(o_char_valid && prev_busy))
                else abort_run($sformatf("%s: char sent while the serial port was busy", test_name));
            if (o_char_valid) begin
                assert (char_count < expected_text.len())
                    else abort_run($sformatf("%s: more characters than the dump text", test_name));
                assert (o_char == expected_text[char_count])
                    else abort_run($sformatf("[ERROR] %s char %0d: expected 8'h%02h actual 8'h%02h",
                                             test_name, char_count, expected_text[char_count],
                                             o_char));
                char_count++;
            end
            prev_valid = o_char_valid;
            prev_busy  = serial_busy;    // level seen at the next edge
        end
    end

    always @(posedge clk) begin
        serial_busy <= bp_on ? 1'($urandom_range(0, 1)) : 1'b0;
    end

    task automatic wait_for_chars(input int n);
        int cycles;
        cycles = 0;
        while (char_count < n) begin
            @(negedge clk);
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                abort_run($sformatf("%s: timed out waiting for character %0d", test_name, n));
            end
        end
    endtask

    task automatic wait_until_idle();
        int cycles;
        cycles = 0;
        while (o_busy) begin
            @(negedge clk);
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                abort_run($sformatf("%s: timed out waiting for the dump to finish", test_name));
            end
        end
    endtask

    // new CPU state plus a start pulse, which a busy DUT must ignore
    task automatic scramble_inputs();
        @(posedge clk);
        pc         <= 20'($urandom);
        alu_mode   <= 1'($urandom);
        rstk_ptr   <= 3'($urandom);
        p          <= 4'($urandom);
        hst        <= 4'($urandom);
        st         <= 16'($urandom);
        dump_start <= 1'b1;
        @(posedge clk);
        dump_start <= 1'b0;
    endtask

    task automatic run_dump(input string name, input logic [PC_W-1:0] pc_v, input logic mode_v,
                            input logic [RSTK_PTR_W-1:0] rp_v, input logic [P_W-1:0] p_v,
                            input logic [HST_W-1:0] hst_v, input logic [ST_W-1:0] st_v,
                            input bit disturb);
        test_name     = name;
        expected_text = expected_dump(pc_v, mode_v, rp_v, p_v, hst_v, st_v);
        char_count    = 0;
        @(posedge clk);
        pc         <= pc_v;
        alu_mode   <= mode_v;
        rstk_ptr   <= rp_v;
        p          <= p_v;
        hst        <= hst_v;
        st         <= st_v;
        dump_start <= 1'b1;
        @(posedge clk);
        dump_start <= 1'b0;
        @(negedge clk);
        assert (o_busy) else abort_run($sformatf("%s: dump start was not accepted", name));
        if (disturb) begin
            scramble_inputs();           // still filling the buffer
            wait_for_chars(20);
            scramble_inputs();
            wait_for_chars(45);
            scramble_inputs();
        end
        wait_until_idle();
        assert (char_count == DUMP_LEN)
            else abort_run($sformatf("[ERROR] %s char count: expected %0d actual %0d",
                                     name, DUMP_LEN, char_count));
        repeat (4) @(negedge clk);
        assert (!o_busy) else abort_run($sformatf("%s: a start during busy began a dump", name));
    endtask

    initial begin
        void'($urandom(RANDOM_SEED));
        dump_start = 1'b0;
        pc         = '0;
        alu_mode   = 1'b0;
        rstk_ptr   = '0;
        p          = '0;
        hst        = '0;
        st         = '0;
        serial_busy = 1'b0;

        test_name = "reset";
        @(negedge clk);                  // reset is driven by now
        for (int cycles = 0; reset; cycles++) begin
            @(negedge clk);
            if (cycles > WAIT_LIMIT) begin
                abort_run("reset was never released");
            end
        end
        @(negedge clk);
        assert (!o_busy && !o_char_valid)
            else abort_run("busy or char valid high after reset");

        run_dump("fixed", 20'hABCDE, 1'b0, 3'd5, 4'hF, 4'b1010, 16'hC35A, 1'b0);

        for (int i = 0; i < 20; i++) begin
            run_dump($sformatf("random_%0d", i), 20'($urandom),
                     (i < 2) ? 1'(i) : 1'($urandom), 3'($urandom), 4'($urandom),
                     4'($urandom), 16'($urandom), 1'b0);
        end

        bp_on = 1'b1;
        for (int i = 0; i < 4; i++) begin
            run_dump($sformatf("backpressure_%0d", i), 20'($urandom), 1'($urandom),
                     3'($urandom), 4'($urandom), 4'($urandom), 16'($urandom), 1'b0);
        end

        run_dump("isolation_bp", 20'h5F0A1, 1'b1, 3'd7, 4'h9, 4'b0110, 16'hFFFF, 1'b1);
        bp_on = 1'b0;
        run_dump("isolation", 20'h00000, 1'b0, 3'd0, 4'h0, 4'b0000, 16'h0000, 1'b1);

        $display("Simulation passed");
        $finish;
    end

endmodule

// ==== all.f ====
rtl/dbg_pkg.sv
rtl/dbg_buf_if.sv
rtl/dbg_sequencer.sv
rtl/dbg_snapshot.sv
rtl/dbg_char_gen.sv
rtl/dbg_text_buffer.sv
rtl/dbg_dump_top.sv
bench/tb_clock_gen.sv
bench/tb_dbg_dump.sv

// ==== Makefile ====
# Verilator build of the register-dump formatter testbench

VERILATOR ?= verilator
TOP       ?= tb_dbg_dump
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: compile
	./$(SIM_BIN)

clean:
	rm -rf $(BUILD_DIR)
